// File: design/cluster_fork.sv
`timescale 1ns/1ps

module cluster_fork #(
  parameter int unsigned NrClusters = shuffle_pkg::DefNrClusters
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  output logic                  ready_o,
  output logic [NrClusters-1:0] valid_o,
  input  logic [NrClusters-1:0] ready_i
);

  logic [NrClusters-1:0] taken_q;
  logic [NrClusters-1:0] taken_now;
  logic [NrClusters-1:0] done;

  // Offer the beat only to clusters that still need it
  assign valid_o   = {NrClusters{valid_i}} & ~taken_q;
  assign taken_now = valid_o & ready_i;
  assign done      = taken_q | taken_now;

  // Upstream sees the transfer once the last cluster has its copy
  assign ready_o = &done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= '0;
    end else if (valid_i) begin
      if (ready_o) begin
        taken_q <= '0;
      end else begin
        taken_q <= done;
      end
    end
  end

endmodule

// File: design/shuffle_permute.sv
`timescale 1ns/1ps

module shuffle_permute #(
  parameter int unsigned NrLanes          = shuffle_pkg::DefNrLanes,
  parameter int unsigned NrClusters       = shuffle_pkg::DefNrClusters,
  parameter int unsigned ClusterDataWidth = shuffle_pkg::DefClusterDataWidth,
  parameter int unsigned Scale            = 0
) (
  input  logic [NrClusters*ClusterDataWidth-1:0] data_i,
  input  logic                                   enable_i,
  output logic [NrClusters*ClusterDataWidth-1:0] data_o
);

  localparam int unsigned TotalWidth = NrClusters * ClusterDataWidth;
  localparam int unsigned BlockSize  = NrLanes << Scale;
  localparam int unsigned GroupSize  = 2 * NrClusters;
  localparam int unsigned NumGroups  = TotalWidth / (BlockSize * GroupSize);

  logic [TotalWidth-1:0] shuffled;

  // Interleave the two halves of every group of 2*NrClusters blocks
  for (genvar k = 0; k < NumGroups; k++) begin : g_group
    for (genvar i = 0; i < NrClusters; i++) begin : g_cluster
      for (genvar j = 0; j < 2; j++) begin : g_half
        localparam int unsigned DstBlk = k * GroupSize + 2 * i + j;
        localparam int unsigned SrcBlk = k * GroupSize + j * NrClusters + i;

        assign shuffled[DstBlk*BlockSize +: BlockSize] =
            data_i[SrcBlk*BlockSize +: BlockSize];
      end
    end
  end

  // Disabled stages leave the beat untouched
  assign data_o = enable_i ? shuffled : data_i;

endmodule

// File: design/shuffle_pkg.sv
package shuffle_pkg;

  //////////////////////////////
  // Element width
  //////////////////////////////

  // Code 3 is reserved; the 64-bit path is not part of this shuffler
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } vew_e;

  //////////////////////////////
  // Request tracking
  //////////////////////////////

  // Outstanding read requests that can be tracked at once
  localparam int unsigned NumTrackers = 8;

  // Index into the tracker entries
  typedef logic [2:0] trk_ptr_t;

  //////////////////////////////
  // Default sizes
  //////////////////////////////

  // Lanes per cluster
  localparam int unsigned DefNrLanes = 4;

  // Clusters fed by one memory beat
  localparam int unsigned DefNrClusters = 4;

  // Slice width delivered to each cluster
  localparam int unsigned DefClusterDataWidth = 128;

endpackage

// File: design/shuffle_read_top.sv
`timescale 1ns/1ps

module shuffle_read_top #(
  parameter int unsigned NrLanes          = shuffle_pkg::DefNrLanes,
  parameter int unsigned NrClusters       = shuffle_pkg::DefNrClusters,
  parameter int unsigned ClusterDataWidth = shuffle_pkg::DefClusterDataWidth
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Read address handshake
  input  logic                                   ar_valid_i,
  input  shuffle_pkg::vew_e                      vew_i,
  input  logic                                   use_eew1_i,
  output logic                                   ar_ready_o,
  output logic                                   ar_valid_o,
  input  logic                                   ar_ready_i,
  // Read data from memory
  input  logic                                   r_valid_i,
  input  logic [NrClusters*ClusterDataWidth-1:0] r_data_i,
  input  logic                                   r_last_i,
  output logic                                   r_ready_o,
  // Read data to the clusters
  output logic [NrClusters-1:0]                  r_valid_o,
  output logic [NrClusters*ClusterDataWidth-1:0] r_data_o,
  output logic                                   r_last_o,
  input  logic [NrClusters-1:0]                  r_ready_i
);

  localparam int unsigned NumStages  = $clog2(ClusterDataWidth / NrLanes);
  localparam int unsigned TotalWidth = NrClusters * ClusterDataWidth;

  logic [TotalWidth-1:0] stage_in  [NumStages];
  logic [TotalWidth-1:0] stage_out [NumStages];
  logic [NumStages-1:0]  stage_valid;
  logic [NumStages-1:0]  stage_ready;
  logic [NumStages-1:0]  stage_last;
  logic [NumStages-1:0]  stage_en;
  logic [NumStages-1:0]  stage_done;

  //////////////////////////////
  // Request tracking
  //////////////////////////////

  shuffle_tracker #(
    .NumStages (NumStages)
  ) i_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_i   (ar_ready_i),
    .vew_i        (vew_i),
    .use_eew1_i   (use_eew1_i),
    .stage_done_i (stage_done),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_o   (ar_ready_o),
    .stage_en_o   (stage_en)
  );

  // Last beat of a request leaving stage s
  assign stage_done = stage_valid & stage_ready & stage_last;

  //////////////////////////////
  // Stage chain
  //////////////////////////////

  // Stage 0 works straight on the memory beat
  assign stage_in[0]    = r_data_i;
  assign stage_valid[0] = r_valid_i;
  assign stage_last[0]  = r_last_i;
  assign r_ready_o      = stage_ready[0];

  for (genvar s = 0; s < NumStages; s++) begin : g_stage
    shuffle_permute #(
      .NrLanes          (NrLanes),
      .NrClusters       (NrClusters),
      .ClusterDataWidth (ClusterDataWidth),
      .Scale            (s)
    ) i_permute (
      .data_i   (stage_in[s]),
      .enable_i (stage_en[s]),
      .data_o   (stage_out[s])
    );

    if (s > 0) begin : g_reg
      shuffle_stage_reg #(
        .Width (TotalWidth)
      ) i_reg (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (stage_valid[s-1]),
        .ready_o (stage_ready[s-1]),
        .data_i  (stage_out[s-1]),
        .last_i  (stage_last[s-1]),
        .valid_o (stage_valid[s]),
        .ready_i (stage_ready[s]),
        .data_o  (stage_in[s]),
        .last_o  (stage_last[s])
      );
    end
  end

  //////////////////////////////
  // Cluster delivery
  //////////////////////////////

  cluster_fork #(
    .NrClusters (NrClusters)
  ) i_fork (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (stage_valid[NumStages-1]),
    .ready_o (stage_ready[NumStages-1]),
    .valid_o (r_valid_o),
    .ready_i (r_ready_i)
  );

  // Cluster c reads its slice from bit c*ClusterDataWidth upward
  assign r_data_o = stage_out[NumStages-1];
  assign r_last_o = stage_last[NumStages-1];

endmodule

// File: design/shuffle_stage_reg.sv
`timescale 1ns/1ps

module shuffle_stage_reg #(
  parameter int unsigned Width = 512
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Upstream side
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  input  logic             last_i,
  // Downstream side
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o,
  output logic             last_o
);

  logic             full_q;
  logic [Width-1:0] data_q;
  logic             last_q;

  // Take a new beat when empty or when the held one is leaving this cycle
  assign ready_o = ~full_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
      last_q <= last_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;
  assign last_o  = last_q;

endmodule

// File: design/shuffle_tracker.sv
`timescale 1ns/1ps

module shuffle_tracker #(
  parameter int unsigned NumStages = $clog2(shuffle_pkg::DefClusterDataWidth /
                                            shuffle_pkg::DefNrLanes)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Read address handshake
  input  logic                 ar_valid_i,
  input  logic                 ar_ready_i,
  input  shuffle_pkg::vew_e    vew_i,
  input  logic                 use_eew1_i,
  // Last beat of a request left stage s
  input  logic [NumStages-1:0] stage_done_i,
  output logic                 ar_valid_o,
  output logic                 ar_ready_o,
  output logic [NumStages-1:0] stage_en_o
);

  localparam int unsigned CntWidth = $clog2(shuffle_pkg::NumTrackers) + 1;

  logic [NumStages-1:0]  en_q [shuffle_pkg::NumTrackers];
  shuffle_pkg::trk_ptr_t accept_ptr_q;
  shuffle_pkg::trk_ptr_t issue_ptr_q [NumStages];
  logic [CntWidth-1:0]   cnt_q;
  logic                  full;
  logic                  accept;
  logic                  retire;
  logic [NumStages-1:0]  new_en;

  function automatic shuffle_pkg::trk_ptr_t next_ptr(input shuffle_pkg::trk_ptr_t ptr);
    shuffle_pkg::trk_ptr_t last_ptr;
    last_ptr = shuffle_pkg::trk_ptr_t'(shuffle_pkg::NumTrackers - 1);
    return (ptr == last_ptr) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // Address side
  //////////////////////////////

  assign full       = (cnt_q == CntWidth'(shuffle_pkg::NumTrackers));
  assign ar_valid_o = ar_valid_i;
  assign ar_ready_o = ar_ready_i & ~full;
  assign accept     = ar_valid_i & ar_ready_o;
  assign retire     = stage_done_i[NumStages-1];

  // Stages at or above the element width scale swap blocks
  // Mask loads use every stage
  always_comb begin
    for (int s = 0; s < NumStages; s++) begin
      new_en[s] = use_eew1_i | (s >= 3 + int'(vew_i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int t = 0; t < shuffle_pkg::NumTrackers; t++) begin
        en_q[t] <= '0;
      end
      accept_ptr_q <= '0;
    end else if (accept) begin
      en_q[accept_ptr_q] <= new_en;
      accept_ptr_q       <= next_ptr(accept_ptr_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      case ({accept, retire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  //////////////////////////////
  // Per-stage issue pointers
  //////////////////////////////

  // Each stage moves on to the next request once its last beat has gone through
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NumStages; s++) begin
        issue_ptr_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < NumStages; s++) begin
        if (stage_done_i[s]) begin
          issue_ptr_q[s] <= next_ptr(issue_ptr_q[s]);
        end
      end
    end
  end

  always_comb begin
    for (int s = 0; s < NumStages; s++) begin
      stage_en_o[s] = en_q[issue_ptr_q[s]][s];
    end
  end

endmodule

// File: filelist.f
design/shuffle_pkg.sv
design/shuffle_tracker.sv
design/shuffle_permute.sv
design/shuffle_stage_reg.sv
design/cluster_fork.sv
design/shuffle_read_top.sv
test/shuffle_read_chk.sv
test/tb_shuffle_read.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the read shuffler testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_shuffle_read -f filelist.f \
  -Mdir "$BUILD_DIR" -o sim_tb > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed with status $status"
  exit 1
fi

# Keep running past assertion errors so the testbench can report them
"./$BUILD_DIR/sim_tb" +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$SIM_LOG"; then
  exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

// File: test/shuffle_read_chk.sv
`timescale 1ns/1ps

module shuffle_read_chk #(
  parameter int unsigned NrClusters       = shuffle_pkg::DefNrClusters,
  parameter int unsigned ClusterDataWidth = shuffle_pkg::DefClusterDataWidth
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   ar_valid_o,
  input  logic                                   ar_ready_o,
  input  logic                                   ar_ready_i,
  input  logic [NrClusters-1:0]                  r_valid_o,
  input  logic [NrClusters*ClusterDataWidth-1:0] r_data_o,
  input  logic [NrClusters-1:0]                  r_ready_i
);

  // Number of assertion failures so far
  int unsigned fail_cnt = 0;

  // Nothing is offered while reset is held
  assert property (@(posedge clk_i) !rst_ni |-> (r_valid_o == '0) && !ar_valid_o)
    else begin
      $error("Output valid high during reset");
      fail_cnt++;
    end

  // The tracker only ever masks the memory side ready
  assert property (@(posedge clk_i) disable iff (!rst_ni) ar_ready_o |-> ar_ready_i)
    else begin
      $error("ar_ready_o high while ar_ready_i is low");
      fail_cnt++;
    end

  // A stalled cluster keeps its beat until it takes it
  for (genvar c = 0; c < NrClusters; c++) begin : g_cluster
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o[c] && !r_ready_i[c] |=>
        r_valid_o[c] && $stable(r_data_o[c*ClusterDataWidth +: ClusterDataWidth]))
      else begin
        $error("Cluster %0d beat dropped or changed before its ready", c);
        fail_cnt++;
      end
  end

endmodule

// File: test/tb_shuffle_read.sv
`timescale 1ns/1ps

module tb_shuffle_read;

  localparam int unsigned NrLanes          = shuffle_pkg::DefNrLanes;
  localparam int unsigned NrClusters       = shuffle_pkg::DefNrClusters;
  localparam int unsigned ClusterDataWidth = shuffle_pkg::DefClusterDataWidth;
  localparam int unsigned TotalWidth       = NrClusters * ClusterDataWidth;
  localparam int unsigned NumStages        = $clog2(ClusterDataWidth / NrLanes);
  localparam int unsigned ClkPeriod        = 100;
  localparam int unsigned BeatsPerReq      = 4;
  localparam int unsigned NumRequests      = 3 + 2 + 6 + shuffle_pkg::NumTrackers;
  // Up to 50 cycles per beat when cluster readies are random
  localparam int unsigned TimeoutCycles    = 50 * NumRequests * BeatsPerReq + 200;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  ar_valid_i;
  shuffle_pkg::vew_e     vew_i;
  logic                  use_eew1_i;
  logic                  ar_ready_o;
  logic                  ar_valid_o;
  logic                  ar_ready_i;
  logic                  r_valid_i;
  logic [TotalWidth-1:0] r_data_i;
  logic                  r_last_i;
  logic                  r_ready_o;
  logic [NrClusters-1:0] r_valid_o;
  logic [TotalWidth-1:0] r_data_o;
  logic                  r_last_o;
  logic [NrClusters-1:0] r_ready_i;

  // Reference model state
  shuffle_pkg::vew_e     req_vew_q [$];
  logic                  req_eew1_q [$];
  logic [TotalWidth-1:0] exp_data [$];
  logic                  exp_last [$];
  int unsigned           recv_cnt [NrClusters];
  int unsigned           err_cnt;
  int unsigned           cycle_cnt;
  logic                  rand_ready;

  shuffle_read_top #(
    .NrLanes          (NrLanes),
    .NrClusters       (NrClusters),
    .ClusterDataWidth (ClusterDataWidth)
  ) DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_valid_i (ar_valid_i),
    .vew_i      (vew_i),
    .use_eew1_i (use_eew1_i),
    .ar_ready_o (ar_ready_o),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .r_valid_i  (r_valid_i),
    .r_data_i   (r_data_i),
    .r_last_i   (r_last_i),
    .r_ready_o  (r_ready_o),
    .r_valid_o  (r_valid_o),
    .r_data_o   (r_data_o),
    .r_last_o   (r_last_o),
    .r_ready_i  (r_ready_i)
  );

  bind shuffle_read_top shuffle_read_chk #(
    .NrClusters       (NrClusters),
    .ClusterDataWidth (ClusterDataWidth)
  ) i_chk (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_valid_o (ar_valid_o),
    .ar_ready_o (ar_ready_o),
    .ar_ready_i (ar_ready_i),
    .r_valid_o  (r_valid_o),
    .r_data_o   (r_data_o),
    .r_ready_i  (r_ready_i)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [TotalWidth-1:0] permute_beat(input logic [TotalWidth-1:0] beat,
                                                         input int unsigned scale);
    logic [TotalWidth-1:0] res;
    int unsigned blk;
    int unsigned pos;
    int unsigned src;
    blk = NrLanes << scale;
    for (int unsigned b = 0; b < TotalWidth / blk; b++) begin
      pos = b % (2 * NrClusters);
      // Output block 2i+j comes from input block j*NrClusters+i of its group
      src = b - pos + (pos % 2) * NrClusters + pos / 2;
      for (int unsigned k = 0; k < blk; k++) begin
        res[b*blk+k] = beat[src*blk+k];
      end
    end
    return res;
  endfunction

  function automatic logic [TotalWidth-1:0] expected_beat(input logic [TotalWidth-1:0] beat,
                                                          input shuffle_pkg::vew_e vew,
                                                          input logic eew1);
    logic [TotalWidth-1:0] res;
    res = beat;
    for (int unsigned s = 0; s < NumStages; s++) begin
      if (eew1 || s >= 3 + int'(vew)) begin
        res = permute_beat(res, s);
      end
    end
    return res;
  endfunction

  function automatic logic [TotalWidth-1:0] random_beat();
    logic [TotalWidth-1:0] res;
    for (int unsigned w = 0; w < TotalWidth / 32; w++) begin
      res[w*32 +: 32] = $urandom;
    end
    return res;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic issue_req(input shuffle_pkg::vew_e vew, input logic eew1);
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    vew_i      = vew;
    use_eew1_i = eew1;
    #(ClkPeriod / 4);
    while (!ar_ready_o) begin
      @(negedge clk_i);
      #(ClkPeriod / 4);
    end
    req_vew_q.push_back(vew);
    req_eew1_q.push_back(eew1);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  // Beats of consecutive requests follow each other with no gap
  task automatic send_beats(input int unsigned num_reqs);
    shuffle_pkg::vew_e     vew;
    logic                  eew1;
    logic [TotalWidth-1:0] beat;
    for (int unsigned r = 0; r < num_reqs; r++) begin
      vew  = req_vew_q.pop_front();
      eew1 = req_eew1_q.pop_front();
      for (int unsigned n = 0; n < BeatsPerReq; n++) begin
        beat = random_beat();
        @(negedge clk_i);
        r_valid_i = 1'b1;
        r_data_i  = beat;
        r_last_i  = (n == BeatsPerReq - 1);
        #(ClkPeriod / 4);
        while (!r_ready_o) begin
          @(negedge clk_i);
          #(ClkPeriod / 4);
        end
        exp_data.push_back(expected_beat(beat, vew, eew1));
        exp_last.push_back(r_last_i);
      end
    end
    @(negedge clk_i);
    r_valid_i = 1'b0;
    r_last_i  = 1'b0;
  endtask

  task automatic wait_drained();
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      done = 1'b1;
      for (int unsigned c = 0; c < NrClusters; c++) begin
        if (recv_cnt[c] != exp_data.size()) begin
          done = 1'b0;
        end
      end
    end
  endtask

  task automatic check_cluster(input int unsigned c);
    logic [ClusterDataWidth-1:0] got;
    logic [ClusterDataWidth-1:0] exp;
    got = r_data_o[c*ClusterDataWidth +: ClusterDataWidth];
    assert (recv_cnt[c] < exp_data.size()) else begin
      $display("Cluster %0d took a beat that was never sent, at %0t", c, $time);
      err_cnt++;
    end
    if (recv_cnt[c] < exp_data.size()) begin
      exp = exp_data[recv_cnt[c]][c*ClusterDataWidth +: ClusterDataWidth];
      assert (got == exp) else begin
        $display("ERR %0t r_data_o[%0d] expected %h got %h", $time, c, exp, got);
        err_cnt++;
      end
      assert (r_last_o == exp_last[recv_cnt[c]]) else begin
        $display("ERR %0t r_last_o expected %b got %b", $time, exp_last[recv_cnt[c]],
                 r_last_o);
        err_cnt++;
      end
      recv_cnt[c]++;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Cluster and address readies change on the falling edge
  always @(negedge clk_i) begin
    r_ready_i  = rand_ready ? NrClusters'($urandom) : '1;
    ar_ready_i = rand_ready ? 1'($urandom) : 1'b1;
  end

  // Sample handshakes midway through the low phase
  always @(negedge clk_i) begin
    #(ClkPeriod / 4);
    if (rst_ni) begin
      for (int unsigned c = 0; c < NrClusters; c++) begin
        if (r_valid_o[c] && r_ready_i[c]) begin
          check_cluster(c);
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run still busy after %0d cycles", TimeoutCycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    shuffle_pkg::vew_e rand_vew;
    logic              rand_eew1;
    void'($urandom(32'hef7c_460a));
    rst_ni     = 1'b0;
    ar_valid_i = 1'b0;
    vew_i      = shuffle_pkg::EW8;
    use_eew1_i = 1'b0;
    ar_ready_i = 1'b1;
    r_valid_i  = 1'b0;
    r_data_i   = '0;
    r_last_i   = 1'b0;
    r_ready_i  = '1;
    rand_ready = 1'b0;
    err_cnt    = 0;
    for (int unsigned c = 0; c < NrClusters; c++) begin
      recv_cnt[c] = 0;
    end
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    // Three widths in flight together
    issue_req(shuffle_pkg::EW8, 1'b0);
    issue_req(shuffle_pkg::EW16, 1'b0);
    issue_req(shuffle_pkg::EW32, 1'b0);
    send_beats(3);
    wait_drained();

    // Mask loads run through every stage
    issue_req(shuffle_pkg::EW32, 1'b1);
    issue_req(shuffle_pkg::EW8, 1'b1);
    send_beats(2);
    wait_drained();

    // Clusters and memory stall at random
    rand_ready = 1'b1;
    for (int unsigned r = 0; r < 6; r++) begin
      rand_vew  = shuffle_pkg::vew_e'($urandom_range(2, 0));
      rand_eew1 = 1'($urandom_range(1, 0));
      issue_req(rand_vew, rand_eew1);
    end
    send_beats(6);
    wait_drained();
    rand_ready = 1'b0;

    //////////////////////////////
    // Tracker full
    //////////////////////////////

    for (int unsigned r = 0; r < shuffle_pkg::NumTrackers; r++) begin
      issue_req(shuffle_pkg::vew_e'(r % 3), 1'b0);
    end
    repeat (3) begin
      @(negedge clk_i);
      #(ClkPeriod / 4);
      assert (ar_ready_i && !ar_ready_o) else begin
        $display("ERR %0t ar_ready_o expected 0 got %b", $time, ar_ready_o);
        err_cnt++;
      end
    end
    send_beats(1);
    wait_drained();
    @(negedge clk_i);
    #(ClkPeriod / 4);
    assert (ar_ready_o) else begin
      $display("ERR %0t ar_ready_o expected 1 got %b", $time, ar_ready_o);
      err_cnt++;
    end
    send_beats(shuffle_pkg::NumTrackers - 1);
    wait_drained();

    $display("Checks done: %0d model errors, %0d assertion failures", err_cnt,
             DUT.i_chk.fail_cnt);
    if (err_cnt == 0 && DUT.i_chk.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
